// File: verilog/chachaPkg.sv
//////////////////////////////
// shared types and constants for the ChaCha block core
// imported by every RTL file of the design
//////////////////////////////
package chachaPkg;

    //////////////////////////////
    // data types
    //////////////////////////////

    typedef logic [31:0] word_t;

    // sixteen words in row-major order
    // word index is row * 4 + column
    typedef word_t [15:0] state_t;

    // 0..3 select a column and 4..7 a diagonal
    typedef logic [2:0] qrIndex_t;

    // the twelve ARX steps of one quarter round in execution order
    typedef enum logic [3:0] {
        StepAddAb1,
        StepXorDa1,
        StepRotD1,
        StepAddCd1,
        StepXorBc1,
        StepRotB1,
        StepAddAb2,
        StepXorDa2,
        StepRotD2,
        StepAddCd2,
        StepXorBc2,
        StepRotB2
    } arxStep_t;

    //////////////////////////////
    // round constants
    //////////////////////////////

    // ten double rounds make ChaCha20
    localparam int DefaultDoubleRounds = 10;
    localparam int QrSteps = 12;
    localparam int QrPerDouble = 8;

    // left rotation amounts in step order
    localparam int RotA = 16;
    localparam int RotB = 12;
    localparam int RotC = 8;
    localparam int RotD = 7;

    // one load cycle, twelve steps and one write-back cycle
    localparam int QrCycles = 14;

    // rotate a word left by a fixed amount
    function automatic word_t rotl(word_t x, int unsigned n);
        return (x << n) | (x >> (32 - n));
    endfunction

endpackage

// File: verilog/quarterRoundIf.sv
//////////////////////////////
// operand and result bundle between the state matrix
// and the shared quarter-round engine
//////////////////////////////
`timescale 1ns/1ps

interface quarterRoundIf;
    import chachaPkg::*;

    // request side
    logic  start;
    word_t a;
    word_t b;
    word_t c;
    word_t d;

    // results are valid in the cycle done is high
    word_t resA;
    word_t resB;
    word_t resC;
    word_t resD;
    logic  done;

    modport source (
        output start, a, b, c, d,
        input  resA, resB, resC, resD, done
    );

    modport engine (
        input  start, a, b, c, d,
        output resA, resB, resC, resD, done
    );

endinterface

// File: verilog/quarterRoundUnit.sv
//////////////////////////////
// sequential quarter-round engine
// captures a..d on start and runs one add, xor or rotate per cycle
// done follows start by thirteen cycles
//////////////////////////////
`timescale 1ns/1ps

module quarterRoundUnit (
    input logic           clk,
    input logic           rstN,
    quarterRoundIf.engine qr
);
    import chachaPkg::*;

    localparam arxStep_t LastStep = arxStep_t'(QrSteps - 1);

    word_t    a;
    word_t    b;
    word_t    c;
    word_t    d;
    arxStep_t step;
    logic     running;
    logic     doneQ;

    //////////////////////////////
    // step control
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            running <= 1'b0;
            step    <= StepAddAb1;
            doneQ   <= 1'b0;
        end else begin
            doneQ <= 1'b0;
            if (qr.start) begin
                running <= 1'b1;
                step    <= StepAddAb1;
            end else if (running) begin
                if (step == LastStep) begin
                    running <= 1'b0;
                    doneQ   <= 1'b1;
                end else begin
                    step <= arxStep_t'(step + 4'd1);
                end
            end
        end
    end

    //////////////////////////////
    // ARX datapath
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (qr.start) begin
            a <= qr.a;
            b <= qr.b;
            c <= qr.c;
            d <= qr.d;
        end else if (running) begin
            unique case (step)
                // a += b; d ^= a; d <<<= 16
                StepAddAb1: a <= a + b;
                StepXorDa1: d <= d ^ a;
                StepRotD1:  d <= rotl(d, RotA);
                // c += d; b ^= c; b <<<= 12
                StepAddCd1: c <= c + d;
                StepXorBc1: b <= b ^ c;
                StepRotB1:  b <= rotl(b, RotB);
                // second half with rotations of 8 and 7
                StepAddAb2: a <= a + b;
                StepXorDa2: d <= d ^ a;
                StepRotD2:  d <= rotl(d, RotC);
                StepAddCd2: c <= c + d;
                StepXorBc2: b <= b ^ c;
                StepRotB2:  b <= rotl(b, RotD);
                default: ;
            endcase
        end
    end

    assign qr.resA = a;
    assign qr.resB = b;
    assign qr.resC = c;
    assign qr.resD = d;
    assign qr.done = doneQ;

    // the source must wait for done before the next request
    startWhileRunning: assert property (@(posedge clk) disable iff (!rstN)
        qr.start |-> !running);

    // every done belongs to the start one quarter-round latency earlier
    doneHasStart: assert property (@(posedge clk) disable iff (!rstN)
        qr.done |-> $past(qr.start, QrCycles - 1));

endmodule

// File: verilog/stateMatrix.sv
//////////////////////////////
// working and initial ChaCha matrices
// gathers column or diagonal operands for the engine, scatters results back
// and forms the feed-forward sum into blockOut
//////////////////////////////
`timescale 1ns/1ps

module stateMatrix (
    input  logic                clk,
    input  logic                rstN,
    input  logic                load,
    input  logic                issue,
    input  logic                finish,
    input  chachaPkg::state_t   stateIn,
    input  chachaPkg::qrIndex_t qrIndex,
    output chachaPkg::state_t   blockOut,
    quarterRoundIf.source       qr
);
    import chachaPkg::*;

    state_t   initState;
    state_t   work;
    state_t   workNext;
    state_t   blockSum;
    qrIndex_t activeIndex;

    // word position of one row of a quarter round
    // diagonals shift one column further right per row
    function automatic logic [3:0] wordIndex(qrIndex_t q, logic [1:0] row);
        logic [1:0] col;
        col = q[2] ? (q[1:0] + row) : q[1:0];
        return {row, col};
    endfunction

    //////////////////////////////
    // operand gather
    //////////////////////////////

    // operands leave together with the issue strobe
    assign qr.start = issue;
    assign qr.a     = work[wordIndex(qrIndex, 2'd0)];
    assign qr.b     = work[wordIndex(qrIndex, 2'd1)];
    assign qr.c     = work[wordIndex(qrIndex, 2'd2)];
    assign qr.d     = work[wordIndex(qrIndex, 2'd3)];

    always_ff @(posedge clk) begin
        if (issue) begin
            activeIndex <= qrIndex;
        end
    end

    //////////////////////////////
    // result scatter
    //////////////////////////////

    always_comb begin
        workNext = work;
        if (qr.done) begin
            workNext[wordIndex(activeIndex, 2'd0)] = qr.resA;
            workNext[wordIndex(activeIndex, 2'd1)] = qr.resB;
            workNext[wordIndex(activeIndex, 2'd2)] = qr.resC;
            workNext[wordIndex(activeIndex, 2'd3)] = qr.resD;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            initState <= stateIn;
            work      <= stateIn;
        end else begin
            work <= workNext;
        end
    end

    //////////////////////////////
    // feed-forward addition
    //////////////////////////////

    // finish arrives with the last done so the sum sees the final results
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            blockSum[i] = initState[i] + workNext[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            blockOut <= '0;
        end else if (finish) begin
            blockOut <= blockSum;
        end
    end

    // the sequencer holds its index for the whole quarter round
    indexStable: assert property (@(posedge clk) disable iff (!rstN)
        qr.done |-> qrIndex == activeIndex);

endmodule

// File: verilog/roundSequencer.sv
//////////////////////////////
// block control for the ChaCha core
// counts quarter rounds and double rounds and strobes load, issue and finish
//////////////////////////////
`timescale 1ns/1ps

module roundSequencer #(
    parameter int NumDoubleRounds = chachaPkg::DefaultDoubleRounds
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                start,
    input  logic                done,
    output logic                load,
    output logic                issue,
    output logic                finish,
    output logic                busy,
    output logic                blockReady,
    output chachaPkg::qrIndex_t qrIndex
);
    import chachaPkg::*;

    localparam int CountW = $clog2(NumDoubleRounds + 1);

    logic [CountW-1:0] doubleCount;
    logic              lastInDouble;
    logic              lastQr;

    // a start seen while busy is dropped
    assign load = start && !busy;

    assign lastInDouble = (qrIndex == qrIndex_t'(QrPerDouble - 1));
    assign lastQr = lastInDouble && (doubleCount == CountW'(NumDoubleRounds - 1));

    // the last done of the block closes it
    assign finish = done && lastQr;

    //////////////////////////////
    // round counters
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy        <= 1'b0;
            issue       <= 1'b0;
            blockReady  <= 1'b0;
            qrIndex     <= '0;
            doubleCount <= '0;
        end else begin
            // next quarter round goes out right after the write-back
            issue      <= load || (done && !lastQr);
            blockReady <= finish;

            if (load) begin
                busy        <= 1'b1;
                qrIndex     <= '0;
                doubleCount <= '0;
            end else if (done) begin
                if (lastQr) begin
                    busy <= 1'b0;
                end
                if (lastInDouble) begin
                    qrIndex     <= '0;
                    doubleCount <= doubleCount + 1'b1;
                end else begin
                    qrIndex <= qrIndex + 1'b1;
                end
            end
        end
    end

    // blockReady closes a block that was running one cycle earlier
    readyWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
        blockReady |-> $past(busy) && !busy);

endmodule

// File: verilog/chachaBlock.sv
//////////////////////////////
// ChaCha20 block function top level
// pulse start with stateIn valid and take blockOut on blockReady
//////////////////////////////
`timescale 1ns/1ps

module chachaBlock (
    input  logic              clk,
    input  logic              rstN,
    input  logic              start,
    input  chachaPkg::state_t stateIn,
    output chachaPkg::state_t blockOut,
    output logic              busy,
    output logic              blockReady
);
    import chachaPkg::*;

    logic     load;
    logic     issue;
    logic     finish;
    qrIndex_t qrIndex;

    quarterRoundIf qrBus ();

    // control
    roundSequencer #(
        .NumDoubleRounds(DefaultDoubleRounds)
    ) i_sequencer (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .done       (qrBus.done),
        .load       (load),
        .issue      (issue),
        .finish     (finish),
        .busy       (busy),
        .blockReady (blockReady),
        .qrIndex    (qrIndex)
    );

    // matrix storage and feed-forward
    stateMatrix i_matrix (
        .clk      (clk),
        .rstN     (rstN),
        .load     (load),
        .issue    (issue),
        .finish   (finish),
        .stateIn  (stateIn),
        .qrIndex  (qrIndex),
        .blockOut (blockOut),
        .qr       (qrBus.source)
    );

    // shared ARX engine
    quarterRoundUnit i_qrUnit (
        .clk  (clk),
        .rstN (rstN),
        .qr   (qrBus.engine)
    );

endmodule

// File: tests/chachaBlockTb.sv
//////////////////////////////
// testbench for the ChaCha block core
// vectors are read from tests/chachaStimulus.txt
// run from the project root so the relative path resolves
//////////////////////////////
`timescale 1ns/1ps

module chachaBlockTb;
    import chachaPkg::*;

    // eight quarter rounds of fourteen cycles per double round
    // plus the load cycle
    localparam int ReadyCycle = DefaultDoubleRounds * 8 * 14 + 1;

    logic   clk;
    logic   rstN;
    logic   start;
    state_t stateIn;
    state_t blockOut;
    logic   busy;
    logic   blockReady;

    string       names[$];
    state_t      inputs[$];
    state_t      expects[$];
    state_t      heldBlock;
    logic [31:0] lfsr;
    logic        stimulusLoaded;

    chachaBlock i_dut (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .stateIn    (stateIn),
        .blockOut   (blockOut),
        .busy       (busy),
        .blockReady (blockReady)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic abortRun(string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // three bits give an idle gap of 0 to 7 cycles
    task automatic drawGap(output int gap);
        gap = 0;
        repeat (3) begin
            lfsr = lfsrNext(lfsr);
            gap = gap * 2 + int'(lfsr[0]);
        end
    endtask

    task automatic loadStimulus();
        int          fd;
        int          row;
        int          count;
        string       line;
        string       name;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        state_t      inWords;
        state_t      outWords;
        fd = $fopen("tests/chachaStimulus.txt", "r");
        assert (fd != 0) else abortRun("cannot open tests/chachaStimulus.txt");
        row = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 1) == "//") continue;
            if (row == 0) begin
                count = $sscanf(line, "%s", name);
            end else begin
                count = $sscanf(line, "%h %h %h %h", w0, w1, w2, w3);
                assert (count == 4) else abortRun({"malformed stimulus line: ", line});
                if (row <= 4) inWords[(row - 1) * 4 +: 4] = {w3, w2, w1, w0};
                else outWords[(row - 5) * 4 +: 4] = {w3, w2, w1, w0};
            end
            row = (row == 8) ? 0 : row + 1;
            if (row == 0) begin
                names.push_back(name);
                inputs.push_back(inWords);
                expects.push_back(outWords);
            end
        end
        $fclose(fd);
        assert (row == 0 && names.size() > 0) else abortRun("stimulus file empty or cut short");
    endtask

    task automatic checkIdle(string name);
        assert (!busy && !blockReady) else abortRun($sformatf(
            "%s: busy or blockReady high while no block runs", name));
        assert (blockOut == heldBlock) else abortRun($sformatf(
            "error: %s blockOut hold expected %h actual %h", name, heldBlock, blockOut));
    endtask

    task automatic idleCycles(int n, string name);
        repeat (n) begin
            @(posedge clk);
            start <= 1'b0;
            @(negedge clk);
            checkIdle(name);
        end
    endtask

    // one block from start to blockReady
    // a nonzero pokeCycle adds a start while busy
    task automatic runBlock(int idx, int pokeCycle);
        int k;
        @(posedge clk);
        start   <= 1'b1;
        stateIn <= inputs[idx];
        @(negedge clk);
        checkIdle(names[idx]);
        k = 0;
        while (k < ReadyCycle) begin
            @(posedge clk);
            k++;
            start <= (k == pokeCycle);
            if (k == pokeCycle) stateIn <= ~inputs[idx];
            @(negedge clk);
            if (k < ReadyCycle) begin
                assert (busy && !blockReady) else abortRun($sformatf(
                    "%s: busy low or early blockReady in cycle %0d", names[idx], k));
                assert (blockOut == heldBlock) else abortRun($sformatf(
                    "error: %s blockOut hold expected %h actual %h",
                    names[idx], heldBlock, blockOut));
            end
        end
        assert (blockReady && !busy) else abortRun($sformatf(
            "%s: no blockReady with busy low in cycle %0d", names[idx], ReadyCycle));
        for (int i = 0; i < 16; i++) begin
            assert (blockOut[i] == expects[idx][i]) else abortRun($sformatf(
                "error: %s word %0d expected %08h actual %08h",
                names[idx], i, expects[idx][i], blockOut[i]));
        end
        heldBlock = expects[idx];
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        int gap;
        rstN           = 1'b0;
        start          = 1'b0;
        stateIn        = '0;
        heldBlock      = '0;
        lfsr           = 32'h018eea57;
        stimulusLoaded = 1'b0;
        loadStimulus();
        stimulusLoaded = 1'b1;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkIdle("afterReset");

        // every vector once with an ignored start in the middle
        foreach (names[i]) begin
            runBlock(i, (100 + 250 * i) % 1100 + 1);
            drawGap(gap);
            idleCycles(gap, names[i]);
        end

        // reset in the middle of a block
        @(posedge clk);
        start   <= 1'b1;
        stateIn <= inputs[0];
        @(posedge clk);
        start <= 1'b0;
        repeat (600) @(posedge clk);
        rstN <= 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        heldBlock = '0;
        repeat (ReadyCycle) begin
            @(negedge clk);
            checkIdle("midBlockReset");
        end

        // back-to-back blocks with random gaps
        foreach (names[i]) begin
            drawGap(gap);
            idleCycles(gap, names[i]);
            runBlock(i, 0);
        end
        idleCycles(2, "afterLastBlock");

        $display("STATUS: PASS");
        $finish;
    end

    // two passes over the records plus the reset test and a margin
    initial begin
        wait (stimulusLoaded);
        repeat ((2 * names.size() + 3) * 1200 + 1000) @(posedge clk);
        abortRun("watchdog expired before the test sequence finished");
    end

endmodule

// File: tests/chachaStimulus.txt
// record: a test name line, four rows of input words, four rows of expected output words
// words in hex, row-major, word index = row * 4 + column
rfc8439Block
61707865 3320646e 79622d32 6b206574
03020100 07060504 0b0a0908 0f0e0d0c
13121110 17161514 1b1a1918 1f1e1d1c
00000001 09000000 4a000000 00000000
e4e7f110 15593bd1 1fdd0f50 c47120a3
c7f4d1c7 0368c033 9aaa2204 4e6cd4c3
466482d2 09aa9f07 05d7c214 a2028bd9
d19c12b5 b94e16de e883d0cb 4e3c50a2
allZero
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
zeroKeyCounter0
61707865 3320646e 79622d32 6b206574
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
ade0b876 903df1a0 e56a5d40 28bd8653
b819d2bd 1aed8da0 ccef36a8 c70d778b
7c5941da 8d485751 3fe02477 374ad8b8
f4b8436a 1ca11815 69b687c3 8665eeb2
zeroKeyCounter1
61707865 3320646e 79622d32 6b206574
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000001 00000000 00000000 00000000
bee7079f 7a385155 7c97ba98 0d082d73
a0290fcb 6965e348 3e53c612 ed7aee32
7621b729 434ee69c b03371d5 d539d874
281fed31 45fb0a51 1f0ae1ac 6f4d794b

// File: tb.f
verilog/chachaPkg.sv
verilog/quarterRoundIf.sv
verilog/quarterRoundUnit.sv
verilog/stateMatrix.sv
verilog/roundSequencer.sv
verilog/chachaBlock.sv
tests/chachaBlockTb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := chachaBlockTb
FILELIST := tb.f
OBJDIR   := obj_dir
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

# the log decides pass or fail
run: $(BIN) tests/chachaStimulus.txt
	-./$(BIN) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
